/* verilog/adc_pipe_pkg.sv */
package adc_pipe_pkg;

	//////////////////////////////
	// word geometry
	//////////////////////////////

	// every fifo and pipe word
	localparam int word_width = 16;

	// frame sequence number, wraps silently
	localparam int seq_width = 12;

	// tag takes what the sequence leaves
	localparam int tag_width = word_width - seq_width;

	// marks a header in the top nibble
	localparam logic [tag_width-1:0] header_tag = 4'ha;

	//////////////////////////////
	// pipe word
	//////////////////////////////

	// one fifo word, seen two ways
	// header: tag in the top bits, then the frame sequence
	// sample: the raw adc word, untouched
	typedef union packed {
		struct packed {
			logic [tag_width-1:0] tag;
			logic [seq_width-1:0] seq;
		} hdr;
		logic [word_width-1:0] raw;
	} pipe_word_u;

endpackage

/* verilog/adc_frame_packer.sv */
`timescale 1ns/10ps

module adc_frame_packer #(
	parameter int N_ADC = 6,
	parameter int FIFO_DEPTH = 32
) (
	input logic sys_clk_in,
	input logic reset_in,

	// adc controller side
	input logic adc_valid_in,
	input logic [$clog2(N_ADC)-1:0] adc_channel_in,
	input logic [adc_pipe_pkg::word_width-1:0] adc_data_in,

	// fifo write side
	input logic [1:0] credit_return,
	output logic fifo_wr_en,
	output logic [adc_pipe_pkg::word_width-1:0] fifo_wr_data,

	// frames thrown away for lack of credit
	output logic [adc_pipe_pkg::word_width-1:0] drop_count
);

	import adc_pipe_pkg::*;

	//////////////////////////////
	// sizes
	//////////////////////////////

	// header plus one word per channel
	localparam int frame_words = N_ADC + 1;
	localparam int cred_w = $clog2(FIFO_DEPTH + 1);
	localparam int ch_w = $clog2(N_ADC);

	//////////////////////////////
	// state
	//////////////////////////////

	// one credit per free fifo slot
	logic [cred_w-1:0] credits;
	logic [seq_width-1:0] seq_num;
	// high between an accepted channel 0 and the last channel
	logic collecting;
	logic [word_width-1:0] stash_data;
	logic stash_vld;

	// decode of the incoming sample
	logic is_first;
	logic is_last;
	logic start_ok;
	logic take_sample;
	pipe_word_u hdr_word;

	assign is_first = adc_valid_in && (adc_channel_in == '0);
	assign is_last = adc_channel_in == ch_w'(N_ADC - 1);

	// whole frame must fit, otherwise nothing of it goes in
	assign start_ok = is_first && (credits >= cred_w'(frame_words));

	// channel 0 of a kept frame, or any later channel of it
	assign take_sample = start_ok || (adc_valid_in && collecting && !is_first);

	//////////////////////////////
	// fifo write port
	//////////////////////////////

	// header for the frame being opened
	always_comb begin
		hdr_word.hdr.tag = header_tag;
		hdr_word.hdr.seq = seq_num;
	end

	// header goes out in the channel 0 cycle
	// the stash always drains one cycle after its sample
	// the idle gap between samples keeps the two apart
	assign fifo_wr_en = start_ok || stash_vld;
	assign fifo_wr_data = start_ok ? hdr_word.raw : stash_data;

	//////////////////////////////
	// credit counter
	//////////////////////////////

	// full frame reserved up front, so the writes themselves cost nothing more
	always_ff @(posedge sys_clk_in) begin
		if (reset_in) begin
			credits <= cred_w'(FIFO_DEPTH);
		end else if (start_ok) begin
			credits <= credits + cred_w'(credit_return) - cred_w'(frame_words);
		end else begin
			credits <= credits + cred_w'(credit_return);
		end
	end

	//////////////////////////////
	// frame tracking
	//////////////////////////////

	// sequence moves on every frame start, kept or not
	always_ff @(posedge sys_clk_in) begin
		if (reset_in) begin
			collecting <= 1'b0;
			seq_num <= '0;
			drop_count <= '0;
		end else if (is_first) begin
			collecting <= start_ok;
			seq_num <= seq_num + 1'b1;
			if (!start_ok) begin
				drop_count <= drop_count + 1'b1;
			end
		end else if (adc_valid_in && is_last) begin
			// frame complete, or a dropped one ends
			collecting <= 1'b0;
		end
	end

	// one-word sample stash
	always_ff @(posedge sys_clk_in) begin
		if (reset_in) begin
			stash_vld <= 1'b0;
		end else begin
			stash_vld <= take_sample;
		end
	end

	always_ff @(posedge sys_clk_in) begin
		if (take_sample) begin
			stash_data <= adc_data_in;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// returned credits never outrun what was written
	credit_bound_a: assert property (@(posedge sys_clk_in) disable iff (reset_in)
		credits <= cred_w'(FIFO_DEPTH));

	// stash relies on the idle cycle after every sample
	sample_gap_a: assert property (@(posedge sys_clk_in) disable iff (reset_in)
		adc_valid_in |=> !adc_valid_in);

endmodule

/* verilog/async_word_fifo.sv */
`timescale 1ns/10ps

module async_word_fifo #(
	parameter int FIFO_DEPTH = 32
) (
	input logic sys_clk_in,
	input logic ti_clk_in,
	input logic reset_in,

	// write side, sys_clk_in
	input logic wr_en,
	input logic [adc_pipe_pkg::word_width-1:0] wr_data,
	output logic [1:0] credit_return,

	// read side, ti_clk_in
	input logic rd_en,
	output logic [adc_pipe_pkg::word_width-1:0] rd_data,
	output logic [$clog2(FIFO_DEPTH):0] fifo_level
);

	import adc_pipe_pkg::*;

	// pointers carry one wrap bit above the address
	localparam int aw = $clog2(FIFO_DEPTH);

	logic [word_width-1:0] mem [FIFO_DEPTH];

	// write domain
	logic [aw:0] wr_bin;
	logic [aw:0] wr_bin_inc;
	logic [aw:0] wr_gray;
	logic [aw:0] rd_gray_m;
	logic [aw:0] rd_gray_s;
	logic [aw:0] rd_sync_bin;
	logic [aw:0] rd_prev_bin;
	logic [aw:0] rd_adv;

	// read domain
	logic [aw:0] rd_bin;
	logic [aw:0] rd_bin_inc;
	logic [aw:0] rd_gray;
	logic [aw:0] wr_gray_m;
	logic [aw:0] wr_gray_s;
	logic [aw:0] wr_sync_bin;

	//////////////////////////////
	// gray helpers
	//////////////////////////////

	function automatic logic [aw:0] bin2gray(input logic [aw:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [aw:0] gray2bin(input logic [aw:0] g);
		logic [aw:0] b;
		integer i;
		b[aw] = g[aw];
		// each bit folds in everything above it
		for (i = aw - 1; i >= 0; i = i - 1) begin
			b[i] = b[i + 1] ^ g[i];
		end
		return b;
	endfunction

	//////////////////////////////
	// write side
	//////////////////////////////

	always_ff @(posedge sys_clk_in) begin
		if (wr_en) begin
			mem[wr_bin[aw-1:0]] <= wr_data;
		end
	end

	assign wr_bin_inc = wr_bin + 1'b1;

	// no full check, the packer only writes against credit
	always_ff @(posedge sys_clk_in) begin
		if (reset_in) begin
			wr_bin <= '0;
			wr_gray <= '0;
		end else if (wr_en) begin
			wr_bin <= wr_bin_inc;
			wr_gray <= bin2gray(wr_bin_inc);
		end
	end

	// read pointer into sys_clk_in, two flops
	always_ff @(posedge sys_clk_in) begin
		if (reset_in) begin
			rd_gray_m <= '0;
			rd_gray_s <= '0;
			rd_prev_bin <= '0;
		end else begin
			rd_gray_m <= rd_gray;
			rd_gray_s <= rd_gray_m;
			rd_prev_bin <= rd_sync_bin;
		end
	end

	assign rd_sync_bin = gray2bin(rd_gray_s);

	// slots freed since last cycle
	// read clock is faster, so up to two per sys cycle
	assign rd_adv = rd_sync_bin - rd_prev_bin;
	assign credit_return = rd_adv[1:0];

	//////////////////////////////
	// read side
	//////////////////////////////

	assign rd_bin_inc = rd_bin + 1'b1;

	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			rd_bin <= '0;
			rd_gray <= '0;
		end else if (rd_en) begin
			rd_bin <= rd_bin_inc;
			rd_gray <= bin2gray(rd_bin_inc);
		end
	end

	// registered output, word shows up the cycle after rd_en
	always_ff @(posedge ti_clk_in) begin
		if (rd_en) begin
			rd_data <= mem[rd_bin[aw-1:0]];
		end
	end

	// write pointer into ti_clk_in, two flops
	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			wr_gray_m <= '0;
			wr_gray_s <= '0;
		end else begin
			wr_gray_m <= wr_gray;
			wr_gray_s <= wr_gray_m;
		end
	end

	assign wr_sync_bin = gray2bin(wr_gray_s);

	// conservative level, lags writes by the sync delay
	assign fifo_level = wr_sync_bin - rd_bin;

	//////////////////////////////
	// checks
	//////////////////////////////

	// controller only pops words it has seen arrive
	no_underflow_a: assert property (@(posedge ti_clk_in) disable iff (reset_in)
		rd_en |-> (fifo_level != '0));

endmodule

/* verilog/pipe_controller.sv */
`timescale 1ns/10ps

module pipe_controller #(
	parameter int READ_LEN = 7,
	parameter int FIFO_DEPTH = 32
) (
	input logic ti_clk_in,
	input logic reset_in,

	// fifo read side
	input logic [$clog2(FIFO_DEPTH):0] fifo_level,
	output logic fifo_rd_en,

	// host pipe
	input logic pipe_read_in,
	output logic block_ready
);

	//////////////////////////////
	// states and sizes
	//////////////////////////////

	localparam logic st_wait = 1'b0;
	localparam logic st_read = 1'b1;

	// counter must hold READ_LEN itself
	localparam int cnt_w = $clog2(READ_LEN + 1);
	localparam int lvl_w = $clog2(FIFO_DEPTH) + 1;

	logic cur_state;
	logic next_state;
	logic [cnt_w-1:0] rd_count;
	// all strobes of the block seen
	logic block_done;

	//////////////////////////////
	// outputs
	//////////////////////////////

	// a whole block buffered and nothing in flight
	assign block_ready = (cur_state == st_wait) && (fifo_level >= lvl_w'(READ_LEN));

	assign block_done = rd_count == cnt_w'(READ_LEN);

	// first strobe lands while still waiting, the rest while reading
	assign fifo_rd_en = pipe_read_in && ((cur_state == st_read) || block_ready);

	//////////////////////////////
	// read counter
	//////////////////////////////

	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			rd_count <= '0;
		end else if (block_done) begin
			rd_count <= '0;
		end else if (fifo_rd_en) begin
			rd_count <= rd_count + 1'b1;
		end
	end

	//////////////////////////////
	// state machine
	//////////////////////////////

	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			cur_state <= st_wait;
		end else begin
			cur_state <= next_state;
		end
	end

	// extra read cycle after the last strobe keeps block_ready low for one cycle
	always_comb begin
		next_state = cur_state;
		case (cur_state)
			st_wait: begin
				if (block_ready && pipe_read_in) begin
					next_state = st_read;
				end
			end
			st_read: begin
				if (block_done) begin
					next_state = st_wait;
				end
			end
			default: next_state = st_wait;
		endcase
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// host only strobes once it has been told a block waits
	strobe_gate_a: assert property (@(posedge ti_clk_in) disable iff (reset_in)
		(pipe_read_in && (cur_state == st_wait)) |-> block_ready);

endmodule

/* verilog/adc_pipe_top.sv */
`timescale 1ns/10ps

module adc_pipe_top #(
	parameter int N_ADC = 6,
	parameter int FIFO_DEPTH = 32,
	parameter int READ_LEN = 7
) (
	input logic ti_clk_in,
	input logic sys_clk_in,
	input logic reset_in,

	// adc controller, sys_clk_in
	input logic adc_valid_in,
	input logic [$clog2(N_ADC)-1:0] adc_channel_in,
	input logic [adc_pipe_pkg::word_width-1:0] adc_data_in,
	output logic [adc_pipe_pkg::word_width-1:0] drop_count,

	// host pipe, ti_clk_in
	input logic pipe_read_in,
	output logic block_ready,
	output logic [adc_pipe_pkg::word_width-1:0] data_out
);

	import adc_pipe_pkg::*;

	// packer to fifo
	logic fifo_wr_en;
	logic [word_width-1:0] fifo_wr_data;
	logic [1:0] credit_return;

	// fifo to controller
	logic fifo_rd_en;
	logic [$clog2(FIFO_DEPTH):0] fifo_level;

	//////////////////////////////
	// sys_clk_in side
	//////////////////////////////

	adc_frame_packer #(
		.N_ADC(N_ADC),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_packer (
		.sys_clk_in(sys_clk_in),
		.reset_in(reset_in),
		.adc_valid_in(adc_valid_in),
		.adc_channel_in(adc_channel_in),
		.adc_data_in(adc_data_in),
		.credit_return(credit_return),
		.fifo_wr_en(fifo_wr_en),
		.fifo_wr_data(fifo_wr_data),
		.drop_count(drop_count)
	);

	// clock crossing, rd_data feeds the pipe directly
	async_word_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.sys_clk_in(sys_clk_in),
		.ti_clk_in(ti_clk_in),
		.reset_in(reset_in),
		.wr_en(fifo_wr_en),
		.wr_data(fifo_wr_data),
		.credit_return(credit_return),
		.rd_en(fifo_rd_en),
		.rd_data(data_out),
		.fifo_level(fifo_level)
	);

	//////////////////////////////
	// ti_clk_in side
	//////////////////////////////

	pipe_controller #(
		.READ_LEN(READ_LEN),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_pipe_ctrl (
		.ti_clk_in(ti_clk_in),
		.reset_in(reset_in),
		.fifo_level(fifo_level),
		.fifo_rd_en(fifo_rd_en),
		.pipe_read_in(pipe_read_in),
		.block_ready(block_ready)
	);

endmodule

/* tb/adc_pipe_tb.sv */
`timescale 1ns/10ps

module adc_pipe_tb;

	import adc_pipe_pkg::*;

	localparam int n_adc = 6;
	localparam int fifo_depth = 32;
	localparam int read_len = 7;
	localparam int ch_w = $clog2(n_adc);
	// ti_clk_in cycles a block may take to show up
	localparam int ready_timeout = 200;
	// quiet window once the fifo is empty
	localparam int idle_window = 100;

	// frames in, blocks out and expected new drops for one row
	typedef struct packed {
		int frames;
		int blocks;
		int drops;
	} step_t;

	logic ti_clk_in = 1'b0;
	logic sys_clk_in = 1'b0;
	logic reset_in;
	logic adc_valid_in;
	logic [ch_w-1:0] adc_channel_in;
	logic [word_width-1:0] adc_data_in;
	logic pipe_read_in;
	logic block_ready;
	logic [word_width-1:0] data_out;
	logic [word_width-1:0] drop_count;

	//////////////////////////////
	// reference model state
	//////////////////////////////

	// samples the host should see in order
	logic [word_width-1:0] word_q[$];
	// expected sequence step for each kept frame
	int gap_q[$];
	// words written and not yet read against the packer credit
	int outstanding;
	// dropped since the last kept frame
	int skipped;
	logic [seq_width-1:0] last_seq;
	int errors;

	// fill, drain, overflow, refill, single frame
	step_t steps [5] = '{
		'{1, 1, 0},
		'{3, 3, 0},
		'{8, 4, 4},
		'{2, 2, 0},
		'{1, 1, 0}
	};

	always #2 ti_clk_in = ~ti_clk_in;
	always #3 sys_clk_in = ~sys_clk_in;

	adc_pipe_top #(
		.N_ADC(n_adc),
		.FIFO_DEPTH(fifo_depth),
		.READ_LEN(read_len)
	) uut (
		.ti_clk_in(ti_clk_in),
		.sys_clk_in(sys_clk_in),
		.reset_in(reset_in),
		.adc_valid_in(adc_valid_in),
		.adc_channel_in(adc_channel_in),
		.adc_data_in(adc_data_in),
		.drop_count(drop_count),
		.pipe_read_in(pipe_read_in),
		.block_ready(block_ready),
		.data_out(data_out)
	);

	task automatic fail_stop(input string msg);
		errors = errors + 1;
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	//////////////////////////////
	// adc model, sys_clk_in
	//////////////////////////////

	task automatic send_frame();
		logic [word_width-1:0] sample;
		bit keep;
		bit was_empty;
		int ch;
		was_empty = (outstanding == 0);
		// whole frame needs credit at channel 0
		keep = (fifo_depth - outstanding) >= (n_adc + 1);
		if (keep) begin
			gap_q.push_back(skipped + 1);
			outstanding = outstanding + n_adc + 1;
			skipped = 0;
		end else begin
			// a dropped frame still uses up a sequence number
			skipped = skipped + 1;
		end
		for (ch = 0; ch < n_adc; ch++) begin
			sample = word_width'($urandom);
			if (keep) begin
				word_q.push_back(sample);
			end
			@(posedge sys_clk_in);
			adc_valid_in <= 1'b1;
			adc_channel_in <= ch_w'(ch);
			adc_data_in <= sample;
			@(negedge ti_clk_in);
			// partial frame must never look like a block
			if (was_empty) begin
				assert (block_ready === 1'b0) else
					fail_stop($sformatf("Fail block_ready: got %h expected %h",
						block_ready, 1'b0));
			end
			// idle cycle after every sample
			@(posedge sys_clk_in);
			adc_valid_in <= 1'b0;
		end
	endtask

	//////////////////////////////
	// host model, ti_clk_in
	//////////////////////////////

	task automatic read_block();
		pipe_word_u got;
		logic [word_width-1:0] exp_word;
		logic [seq_width-1:0] seq_step;
		int gap;
		int wait_cnt;
		int i;
		wait_cnt = 0;
		@(negedge ti_clk_in);
		while (block_ready !== 1'b1 && wait_cnt < ready_timeout) begin
			@(negedge ti_clk_in);
			wait_cnt++;
		end
		assert (block_ready === 1'b1) else
			fail_stop("block_ready did not rise before the timeout");
		@(posedge ti_clk_in);
		pipe_read_in <= 1'b1;
		for (i = 0; i < read_len; i++) begin
			@(posedge ti_clk_in);
			if (i == read_len - 1) begin
				pipe_read_in <= 1'b0;
			end
			// word popped on the edge just gone
			@(negedge ti_clk_in);
			got.raw = data_out;
			if (i == 0) begin
				gap = gap_q.pop_front();
				seq_step = got.hdr.seq - last_seq;
				assert (got.hdr.tag === 4'ha) else
					fail_stop($sformatf("Fail data_out tag: got %h expected %h",
						got.hdr.tag, 4'ha));
				// drops show up as a jump in the sequence
				assert (seq_step === seq_width'(gap)) else
					fail_stop($sformatf("Fail data_out seq step: got %h expected %h",
						seq_step, seq_width'(gap)));
				last_seq = got.hdr.seq;
			end else begin
				exp_word = word_q.pop_front();
				assert (data_out === exp_word) else
					fail_stop($sformatf("Fail data_out: got %h expected %h",
						data_out, exp_word));
			end
		end
		outstanding = outstanding - read_len;
	endtask

	// no block may be offered by an empty fifo
	task automatic check_idle();
		int i;
		for (i = 0; i < idle_window; i++) begin
			@(negedge ti_clk_in);
			assert (block_ready === 1'b0) else
				fail_stop($sformatf("Fail block_ready: got %h expected %h", block_ready, 1'b0));
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int row;
		int f;
		int b;
		logic [word_width-1:0] exp_drops;
		void'($urandom(32'hb4f4b6ed));
		errors = 0;
		outstanding = 0;
		skipped = 0;
		exp_drops = '0;
		// first header then steps by one
		last_seq = '1;
		reset_in = 1'b1;
		adc_valid_in = 1'b0;
		adc_channel_in = '0;
		adc_data_in = '0;
		pipe_read_in = 1'b0;
		repeat (2) @(posedge sys_clk_in);
		reset_in <= 1'b0;
		repeat (4) @(posedge sys_clk_in);
		@(negedge ti_clk_in);
		assert (block_ready === 1'b0) else
			fail_stop($sformatf("Fail block_ready: got %h expected %h", block_ready, 1'b0));
		assert (drop_count === '0) else
			fail_stop($sformatf("Fail drop_count: got %h expected %h", drop_count, 16'h0));
		for (row = 0; row < 5; row++) begin
			for (f = 0; f < steps[row].frames; f++) begin
				send_frame();
			end
			repeat (8) @(posedge sys_clk_in);
			@(negedge sys_clk_in);
			exp_drops = exp_drops + word_width'(steps[row].drops);
			assert (drop_count === exp_drops) else
				fail_stop($sformatf("Fail drop_count: got %h expected %h", drop_count,
					exp_drops));
			for (b = 0; b < steps[row].blocks; b++) begin
				read_block();
			end
			if (word_q.size() == 0) begin
				check_idle();
			end
			// let freed slots come back as credit
			repeat (8) @(posedge sys_clk_in);
		end
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* adc_pipe_top.f */
verilog/adc_pipe_pkg.sv
verilog/adc_frame_packer.sv
verilog/async_word_fifo.sv
verilog/pipe_controller.sv
verilog/adc_pipe_top.sv
tb/adc_pipe_tb.sv

/* Makefile */
TOP := adc_pipe_tb
SRCS := $(shell cat adc_pipe_top.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): adc_pipe_top.f $(SRCS)
	verilator --binary --assert --top-module $(TOP) -f adc_pipe_top.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
